// ==== verilog/game_config.svh ====
//**************************************************************************
// Game constants for the enemy block. Include wherever enemy counts,
// sprite geometry, playfield bounds or move timing are needed.
//**************************************************************************

`ifndef GAME_CONFIG_SVH
`define GAME_CONFIG_SVH

// Enemy group
`define ENEMY_COUNT   3
`define ENEMY_SIZE    26     // Sprite is square

// Player hit box
`define PLAYER_WIDTH  18
`define PLAYER_HEIGHT 20

// Walkable area in screen pixels
`define X_MIN         0
`define X_MAX         319
`define Y_MIN         52
`define Y_MAX         205

// Motion pacing
`define STEP_SIZE     1      // Pixels per move tick
`define TICK_DIVIDE   4      // Frame edges per move tick

`endif

// ==== verilog/gamePkg.sv ====
//**************************************************************************
// Shared types of the enemy block: screen coordinates, positions, sprite
// addresses, facing and walk phase. Import into any module using them.
//**************************************************************************

`include "game_config.svh"

package gamePkg;

    typedef logic [8:0] coord_t;          // Covers the 320 wide screen

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    typedef logic [12:0] spriteAddr_t;    // Twelve frames of 26x26 pixels

    // Facing, also the row of frames in the sprite sheet
    typedef enum logic [1:0] {
        dirDown  = 2'd0,
        dirLeft  = 2'd1,
        dirUp    = 2'd2,
        dirRight = 2'd3
    } dir_t;

    typedef logic [1:0] walkPhase_t;

    typedef logic [`ENEMY_COUNT-1:0] enemyMask_t;    // One bit per enemy

endpackage

// ==== verilog/frameTicker.sv ====
//**************************************************************************
// Turns the frame level into a one-cycle move tick on every
// TICK_DIVIDE-th rising frame edge. One instance serves all enemies.
//**************************************************************************

`include "game_config.svh"

module frameTicker (
    input  logic Clk,
    input  logic reset,
    input  logic frameSync,
    output logic moveTick
);

    localparam int unsigned cntWidth = $clog2(`TICK_DIVIDE);
    localparam logic [cntWidth-1:0] lastCount = cntWidth'(`TICK_DIVIDE - 1);

    logic                frameDly;    // Frame level one cycle back
    logic                edgePulse;
    logic [cntWidth-1:0] edgeCount;

    always_ff @(posedge Clk) begin
        if (reset) begin
            frameDly  <= 1'b0;
            edgePulse <= 1'b0;
            edgeCount <= '0;
            moveTick  <= 1'b0;
        end else begin
            frameDly  <= frameSync;
            edgePulse <= frameSync && !frameDly;
            moveTick  <= 1'b0;
            if (edgePulse) begin
                if (edgeCount == lastCount) begin
                    edgeCount <= '0;
                    moveTick  <= 1'b1;    // Every fourth edge
                end else begin
                    edgeCount <= edgeCount + 1'b1;
                end
            end
        end
    end

    // Edge pulses are one cycle long, so ticks never run back to back
    assert property (@(posedge Clk) disable iff (reset) moveTick |=> !moveTick);

endmodule

// ==== verilog/walkAnimator.sv ====
//**************************************************************************
// Walk phase counter of one enemy. Advances on move ticks while the
// enemy steps and falls back to the idle frame when it stands.
//**************************************************************************

module walkAnimator
    import gamePkg::*;
(
    input  logic       Clk,
    input  logic       reset,
    input  logic       moveTick,
    input  logic       moving,
    output walkPhase_t phase
);

    always_ff @(posedge Clk) begin
        if (reset) begin
            phase <= '0;
        end else if (moveTick) begin
            if (moving) begin
                phase <= phase + 1'b1;    // Wraps after 3
            end else begin
                phase <= '0;              // Idle frame
            end
        end
    end

endmodule

// ==== verilog/enemyChaser.sv ====
//**************************************************************************
// One enemy: chases the player on move ticks, flags attack readiness when
// it stood still, and maps the scanned pixel to a sprite-ROM address.
//**************************************************************************

`include "game_config.svh"

module enemyChaser
    import gamePkg::*;
#(
    parameter int enemyId = 0
) (
    input  logic        Clk,
    input  logic        reset,
    input  logic        moveTick,
    input  logic        alive,
    input  pos_t        player,
    input  pos_t        pixel,
    output pos_t        enemyPos,
    output logic        attackReady,
    output logic        hit,
    output spriteAddr_t spriteAddr
);

    // Edge math runs one bit wider so sums never wrap
    localparam logic [9:0] enemySpan    = 10'(`ENEMY_SIZE);
    localparam logic [9:0] playerWidth  = 10'(`PLAYER_WIDTH);
    localparam logic [9:0] playerHeight = 10'(`PLAYER_HEIGHT);
    localparam logic [9:0] xMin         = 10'(`X_MIN);
    localparam logic [9:0] xMax         = 10'(`X_MAX);
    localparam logic [9:0] yMin         = 10'(`Y_MIN);
    localparam logic [9:0] yMax         = 10'(`Y_MAX);
    localparam coord_t stepSize = coord_t'(`STEP_SIZE);
    localparam coord_t startX = coord_t'(70 * (enemyId + 1) - `ENEMY_SIZE / 2);
    localparam coord_t startY = coord_t'(40 * (enemyId + 1) - `ENEMY_SIZE / 2);
    localparam spriteAddr_t frameSize = spriteAddr_t'(`ENEMY_SIZE * `ENEMY_SIZE);

    dir_t       dir;
    dir_t       nextDir;
    pos_t       nextPos;
    logic       stepping;    // This tick moves the enemy
    logic       lastMoved;   // Previous alive tick moved it
    walkPhase_t phase;
    logic [9:0] leftX, topY, rightEdge, bottomEdge;
    logic [9:0] playerRight, playerBottom;
    coord_t     dx, dy;
    logic [3:0] dirBase, frameIdx;

    assign leftX        = {1'b0, enemyPos.x};
    assign topY         = {1'b0, enemyPos.y};
    assign rightEdge    = leftX + enemySpan;
    assign bottomEdge   = topY + enemySpan;
    assign playerRight  = {1'b0, player.x} + playerWidth;
    assign playerBottom = {1'b0, player.y} + playerHeight;

    // Horizontal chase first, then vertical; bounds cancel the step only
    always_comb begin
        nextPos  = enemyPos;
        nextDir  = dir;
        stepping = 1'b0;
        if (rightEdge < {1'b0, player.x}) begin
            nextDir = dirRight;
            if (rightEdge < xMax) begin
                nextPos.x = enemyPos.x + stepSize;
                stepping  = 1'b1;
            end
        end else if (leftX > playerRight) begin
            nextDir = dirLeft;
            if (leftX > xMin) begin
                nextPos.x = enemyPos.x - stepSize;
                stepping  = 1'b1;
            end
        end else if (bottomEdge < {1'b0, player.y}) begin
            nextDir = dirDown;
            if (bottomEdge < yMax) begin
                nextPos.y = enemyPos.y + stepSize;
                stepping  = 1'b1;
            end
        end else if (topY > playerBottom) begin
            nextDir = dirUp;
            if (topY > yMin) begin
                nextPos.y = enemyPos.y - stepSize;
                stepping  = 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            enemyPos.x  <= startX;
            enemyPos.y  <= startY;
            dir         <= dirDown;
            attackReady <= 1'b0;
            lastMoved   <= 1'b0;
        end else if (moveTick && alive) begin    // Dead enemies freeze
            enemyPos    <= nextPos;
            dir         <= nextDir;
            attackReady <= !lastMoved;
            lastMoved   <= stepping;
        end
    end

    walkAnimator walkAnimator_i (
        .Clk      (Clk),
        .reset    (reset),
        .moveTick (moveTick),
        .moving   (alive && stepping),
        .phase    (phase)
    );

    assign hit = alive &&
                 ({1'b0, pixel.x} >= leftX) && ({1'b0, pixel.x} < rightEdge) &&
                 ({1'b0, pixel.y} >= topY) && ({1'b0, pixel.y} < bottomEdge);

    assign dx = pixel.x - enemyPos.x;
    assign dy = pixel.y - enemyPos.y;

    // Three frames per facing: idle, then two stride frames
    assign dirBase  = 4'(dir) * 4'd3;
    assign frameIdx = phase[0] ? dirBase + 4'd1 + 4'(phase[1]) : dirBase;

    assign spriteAddr = hit ? spriteAddr_t'(dx) + spriteAddr_t'(dy) * spriteAddr_t'(`ENEMY_SIZE)
                              + spriteAddr_t'(frameIdx) * frameSize
                            : '0;

    // Start row of enemy 0 lies above Y_MIN, so the top is checked on upward steps only
    assert property (@(posedge Clk) disable iff (reset)
        (rightEdge <= xMax) && (bottomEdge <= yMax) &&
        ((enemyPos.y < $past(enemyPos.y)) -> (topY >= yMin)));

    // Facing only turns at a move tick
    assert property (@(posedge Clk) disable iff (reset) !moveTick |=> $stable(dir));

endmodule

// ==== verilog/spriteMixer.sv ====
//**************************************************************************
// Per-pixel priority mux over the enemies. The lowest-numbered enemy
// covering the pixel owns it and supplies the sprite-ROM address.
//**************************************************************************

`include "game_config.svh"

module spriteMixer
    import gamePkg::*;
(
    input  enemyMask_t                     hits,
    input  spriteAddr_t [`ENEMY_COUNT-1:0] addrs,
    output logic                           spriteHit,
    output spriteAddr_t                    spriteAddr,
    output logic [1:0]                     spriteOwner
);

    // Scan from the top so lower ids overwrite higher ones
    always_comb begin
        spriteHit   = 1'b0;
        spriteAddr  = '0;
        spriteOwner = '0;
        for (int i = `ENEMY_COUNT - 1; i >= 0; i--) begin
            if (hits[i]) begin
                spriteHit   = 1'b1;
                spriteAddr  = addrs[i];
                spriteOwner = 2'(i);
            end
        end
    end

endmodule

// ==== verilog/enemyField.sv ====
//**************************************************************************
// Top level of the enemy block: frame ticker, the enemy array and the
// sprite mixer that feeds the pixel pipeline.
//**************************************************************************

`include "game_config.svh"

module enemyField
    import gamePkg::*;
(
    input  logic                    Clk,
    input  logic                    reset,
    input  logic                    frameSync,
    input  pos_t                    player,
    input  pos_t                    pixel,
    input  enemyMask_t              alive,
    output pos_t [`ENEMY_COUNT-1:0] enemyPos,
    output enemyMask_t              attackReady,
    output logic                    spriteHit,
    output spriteAddr_t             spriteAddr,
    output logic [1:0]              spriteOwner
);

    logic                           moveTick;
    enemyMask_t                     hits;
    spriteAddr_t [`ENEMY_COUNT-1:0] addrs;

    frameTicker frameTicker_i (
        .Clk       (Clk),
        .reset     (reset),
        .frameSync (frameSync),
        .moveTick  (moveTick)
    );

    for (genvar i = 0; i < `ENEMY_COUNT; i++) begin : chaserGen
        enemyChaser #(
            .enemyId (i)
        ) enemyChaser_i (
            .Clk         (Clk),
            .reset       (reset),
            .moveTick    (moveTick),
            .alive       (alive[i]),
            .player      (player),
            .pixel       (pixel),
            .enemyPos    (enemyPos[i]),
            .attackReady (attackReady[i]),
            .hit         (hits[i]),
            .spriteAddr  (addrs[i])
        );
    end

    spriteMixer spriteMixer_i (
        .hits        (hits),
        .addrs       (addrs),
        .spriteHit   (spriteHit),
        .spriteAddr  (spriteAddr),
        .spriteOwner (spriteOwner)
    );

    // Attack flags only change on the cycle after a tick
    assert property (@(posedge Clk) disable iff (reset) !$stable(attackReady) |-> $past(moveTick));

endmodule

// ==== verif/enemyFieldTb.sv ====
//**************************************************************************
// Testbench of the enemy block. Runs frames with random players and pixels
// and compares positions, attack flags and the mixer against a model.
//**************************************************************************

`include "game_config.svh"

module enemyFieldTb
    import gamePkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int frameCycles   = 16;                // 8 high, 8 low
    localparam int totalFrames   = 16 + 150 + 9 + 15;  // Corner, random, attack, dead
    localparam int timeoutCycles = (totalFrames + 10) * frameCycles + 100;

    logic                    Clk, reset, frameSync, spriteHit;
    pos_t                    player, pixel;
    enemyMask_t              alive, attackReady;
    pos_t [`ENEMY_COUNT-1:0] enemyPos;
    spriteAddr_t             spriteAddr;
    logic [1:0]              spriteOwner;

    pos_t        modelPos [`ENEMY_COUNT];
    dir_t        modelDir [`ENEMY_COUNT];
    walkPhase_t  modelPhase [`ENEMY_COUNT];
    enemyMask_t  modelMoved, modelAttack;
    logic [31:0] lfsrState;
    int          frameCount;
    int          cycleCount = 0;

    enemyField enemyField_i (.*);

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout after %0d cycles, the tests did not reach their end", cycleCount);
            $display("Result: FAILED");
            $fatal(1, "Run stopped by timeout");
        end
    end

    function automatic pos_t makePos(input int x, input int y);
        pos_t p;
        p.x = coord_t'(x);
        p.y = coord_t'(y);
        return p;
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] drawBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};    // One step per bit
        end
        return value;
    endfunction

    task automatic failValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic checkPos(input string name, input pos_t got, input pos_t exp);
        if (got !== exp) failValue(name, 32'(got), 32'(exp));    // Shown as {x, y}
    endtask
    task automatic checkMask(input string name, input enemyMask_t got, input enemyMask_t exp);
        if (got !== exp) failValue(name, 32'(got), 32'(exp));
    endtask
    task automatic checkAddr(input string name, input spriteAddr_t got, input spriteAddr_t exp);
        if (got !== exp) failValue(name, 32'(got), 32'(exp));
    endtask
    task automatic checkHit(input string name, input logic got, input logic exp);
        if (got !== exp) failValue(name, 32'(got), 32'(exp));
    endtask
    task automatic checkOwner(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) failValue(name, 32'(got), 32'(exp));
    endtask

    // Chase rules in priority order, a bound cancels the step but not the turn
    task automatic modelTick();
        int   x, y;
        logic stepped;
        for (int i = 0; i < `ENEMY_COUNT; i++) begin
            x = int'(modelPos[i].x);
            y = int'(modelPos[i].y);
            stepped = 1'b0;
            if (alive[i]) begin
                if (x + `ENEMY_SIZE < int'(player.x)) begin
                    modelDir[i] = dirRight;
                    stepped = x + `ENEMY_SIZE < `X_MAX;
                    x += stepped ? `STEP_SIZE : 0;
                end else if (x > int'(player.x) + `PLAYER_WIDTH) begin
                    modelDir[i] = dirLeft;
                    stepped = x > `X_MIN;
                    x -= stepped ? `STEP_SIZE : 0;
                end else if (y + `ENEMY_SIZE < int'(player.y)) begin
                    modelDir[i] = dirDown;
                    stepped = y + `ENEMY_SIZE < `Y_MAX;
                    y += stepped ? `STEP_SIZE : 0;
                end else if (y > int'(player.y) + `PLAYER_HEIGHT) begin
                    modelDir[i] = dirUp;
                    stepped = y > `Y_MIN;
                    y -= stepped ? `STEP_SIZE : 0;
                end
                modelPos[i] = makePos(x, y);
                modelAttack[i] = !modelMoved[i];    // Stood still on the tick before
                modelMoved[i] = stepped;
            end
            modelPhase[i] = stepped ? modelPhase[i] + 2'd1 : 2'd0;
        end
    endtask

    task automatic checkPixel(input pos_t pix);
        int          dx, dy, frame;
        logic        expHit;
        spriteAddr_t expAddr;
        logic [1:0]  expOwner;
        expHit = 1'b0;
        expAddr = '0;
        expOwner = '0;
        pixel = pix;
        #10;
        for (int i = 0; i < `ENEMY_COUNT; i++) begin
            dx = int'(pix.x) - int'(modelPos[i].x);
            dy = int'(pix.y) - int'(modelPos[i].y);
            if (!expHit && alive[i] && dx >= 0 && dx < `ENEMY_SIZE
                    && dy >= 0 && dy < `ENEMY_SIZE) begin    // Lowest id wins
                frame = 3 * int'(modelDir[i]) + (modelPhase[i][0] ? 1 + int'(modelPhase[i][1]) : 0);
                expHit = 1'b1;
                expAddr = spriteAddr_t'(dx + dy * `ENEMY_SIZE + frame * `ENEMY_SIZE * `ENEMY_SIZE);
                expOwner = 2'(i);
            end
        end
        checkHit("spriteHit", spriteHit, expHit);
        checkOwner("spriteOwner", spriteOwner, expOwner);
        checkAddr("spriteAddr", spriteAddr, expAddr);
    endtask

    task automatic checkState();
        for (int i = 0; i < `ENEMY_COUNT; i++) begin
            checkPos($sformatf("enemyPos[%0d]", i), enemyPos[i], modelPos[i]);
        end
        checkMask("attackReady", attackReady, modelAttack);
    endtask

    // Frame high for 8 cycles, then low with new inputs and the checks at its end
    task automatic runFrame(input pos_t nextPlayer, input enemyMask_t nextAlive);
        pos_t        pix;
        logic [31:0] pick;
        int          box;
        @(negedge Clk);
        frameSync = 1'b1;
        frameCount++;
        if (frameCount % `TICK_DIVIDE == 0) modelTick();
        repeat (8) @(negedge Clk);
        frameSync = 1'b0;
        player = nextPlayer;
        alive = nextAlive;
        repeat (3) @(negedge Clk);
        for (int k = 0; k < 4; k++) begin
            @(negedge Clk);
            pick = drawBits(3);
            box = int'(pick[1:0]);
            if (pick[2] && box < `ENEMY_COUNT) begin    // Somewhere inside a model box
                pix.x = modelPos[box].x + coord_t'(drawBits(5) % `ENEMY_SIZE);
                pix.y = modelPos[box].y + coord_t'(drawBits(5) % `ENEMY_SIZE);
            end else begin
                pix = makePos(int'(drawBits(9) % 320), int'(drawBits(8) % 240));
            end
            checkPixel(pix);
        end
        checkState();
    endtask

    initial begin
        pos_t target;
        pos_t frozenPos;
        reset = 1'b1;
        frameSync = 1'b0;
        player = '0;
        pixel = '0;
        alive = '1;
        lfsrState = 32'h945a_d9d3;
        frameCount = 0;
        modelMoved = '0;
        modelAttack = '0;
        for (int i = 0; i < `ENEMY_COUNT; i++) begin
            modelPos[i] = makePos(70 * (i + 1) - `ENEMY_SIZE / 2, 40 * (i + 1) - `ENEMY_SIZE / 2);
            modelDir[i] = dirDown;
            modelPhase[i] = '0;
        end
        repeat (3) @(negedge Clk);
        reset = 1'b0;

        // Start positions, then two rows that miss every box
        checkState();
        for (int k = 0; k < 16; k++) begin
            @(negedge Clk);
            checkPixel(makePos((k % 8) * 40, (k < 8) ? 0 : 200));
        end

        // Player near the top-left corner, enemy 0 wants up but sits above Y_MIN
        repeat (16) runFrame(makePos(60, 0), '1);
        checkPos("enemyPos[0]", enemyPos[0], makePos(57, 27));

        repeat (150) begin
            target = makePos(int'(drawBits(9) % 320), int'(drawBits(8) % 240));
            runFrame(target, '1);
        end

        // Player on top of enemy 0 so it stands for two ticks
        repeat (9) runFrame(modelPos[0], '1);
        checkMask("attackReady[0]", attackReady & enemyMask_t'(1), enemyMask_t'(1));

        // Enemy 0 dead while the player is far away
        frozenPos = modelPos[0];
        repeat (15) runFrame(makePos(300, 200), ~enemyMask_t'(1));
        checkPos("enemyPos[0]", enemyPos[0], frozenPos);
        checkMask("attackReady[0]", attackReady & enemyMask_t'(1), enemyMask_t'(1));
        @(negedge Clk);
        checkPixel(makePos(int'(frozenPos.x) + 13, int'(frozenPos.y) + 13));

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/gamePkg.sv
verilog/frameTicker.sv
verilog/walkAnimator.sv
verilog/enemyChaser.sv
verilog/spriteMixer.sv
verilog/enemyField.sv
verif/enemyFieldTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the enemy block testbench with Verilator, output goes to sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module enemyFieldTb \
    -f list.f -o simv > sim.log 2>&1 && ./obj_dir/simv >> sim.log 2>&1 \
    || echo "Build or simulation ended with an error" >> sim.log
grep -q "Result: FAILED" sim.log || ! grep -q "Result: PASSED" sim.log \
    && { echo "Simulation failed, see sim.log"; exit 1; } || echo "Simulation passed"
